//--- logic/ttc_cfg_pkg.sv
package ttc_cfg_pkg;

  // ------------------------------------------------------------------
  // Channel dimensions
  // ------------------------------------------------------------------

  localparam int cnt_w   = 16;                      // Counter width
  localparam int n_match = 3;                       // Match comparators per channel

  // Wrap point in overflow mode
  localparam logic [cnt_w-1:0] cnt_max = '1;

  // ------------------------------------------------------------------
  // Event strobes, one cycle each
  // ------------------------------------------------------------------

  typedef struct packed {
    logic             interval;                     // Count hit interval value
    logic [n_match:1] match;                        // Per comparator hit
    logic             overflow;                     // Count wrapped at all ones
  } ttc_evt_t;

  // ------------------------------------------------------------------
  // Control as seen by counter and comparators
  // ------------------------------------------------------------------

  typedef struct packed {
    logic enable;                                   // Counting on
    logic interval_mode;                            // Wrap at interval value
    logic restart;                                  // One cycle pulse, zeroes count
  } ttc_ctrl_t;

endpackage

//--- logic/ttc_reg_pkg.sv
package ttc_reg_pkg;

  // ------------------------------------------------------------------
  // Register map, 3 bit word addresses
  // ------------------------------------------------------------------

  localparam logic [2:0] addr_ctrl     = 3'd0;      // enable, interval_mode, restart
  localparam logic [2:0] addr_interval = 3'd1;      // Interval wrap value
  localparam logic [2:0] addr_match1   = 3'd2;
  localparam logic [2:0] addr_match2   = 3'd3;
  localparam logic [2:0] addr_match3   = 3'd4;
  localparam logic [2:0] addr_count    = 3'd5;      // Read only
  localparam logic [2:0] addr_intr     = 3'd6;      // Clears on read
  localparam logic [2:0] addr_intr_en  = 3'd7;

  // Interrupt register width, top bit unused
  localparam int intr_w = 6;

  // Writable bits of the enable register
  localparam logic [intr_w-1:0] intr_en_mask = {1'b0, {(intr_w-1){1'b1}}};

  // ------------------------------------------------------------------
  // Field layouts
  // ------------------------------------------------------------------

  // pwdata on a control write
  typedef struct packed {
    logic [ttc_cfg_pkg::cnt_w-4:0] rsvd;            // Reads zero
    logic                          restart;         // Bit 2
    logic                          interval_mode;   // Bit 1
    logic                          enable;          // Bit 0
  } ttc_ctrl_fld_t;

  // Interrupt and enable register bits
  typedef struct packed {
    logic rsvd;                                     // Bit 5, always zero
    logic overflow;
    logic match3;
    logic match2;
    logic match1;
    logic interval;                                 // Bit 0
  } ttc_intr_fld_t;

endpackage

//--- logic/ttc_regs.sv
module ttc_regs
  import ttc_cfg_pkg::*;
  import ttc_reg_pkg::*;
(
  input  logic                          pclk27,
  input  logic                          n_p_reset27,
  input  logic                          psel,
  input  logic                          pwrite,
  input  logic [2:0]                    paddr,
  input  logic [cnt_w-1:0]              pwdata,
  output logic [cnt_w-1:0]              prdata,
  input  logic [cnt_w-1:0]              count,
  input  logic [intr_w-1:0]             intr_reg,
  input  logic [intr_w-1:0]             intr_en,
  output ttc_ctrl_t                     ctrl,
  output logic [cnt_w-1:0]              interval_val,
  output logic [n_match:1][cnt_w-1:0]   match_val,
  output logic                          intr_en_reg_sel,
  output logic                          clear_interrupt
);

  logic          wr_en;        // Write strobe, any address
  logic          rd_en;        // Read strobe, any address
  ttc_ctrl_fld_t wr_ctrl;      // pwdata seen as control fields

  assign wr_en   = psel && pwrite;
  assign rd_en   = psel && !pwrite;
  assign wr_ctrl = ttc_ctrl_fld_t'(pwdata);

  // Strobes into the interrupt block
  assign intr_en_reg_sel = wr_en && (paddr == addr_intr_en);
  assign clear_interrupt = rd_en && (paddr == addr_intr);    // Read clears

  // ------------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      ctrl         <= '0;
      interval_val <= '0;
      match_val    <= '0;
    end
    else
    begin
      // Restart lives one cycle only
      ctrl.restart <= wr_en && (paddr == addr_ctrl) && wr_ctrl.restart;
      if (wr_en)
      begin
        case (paddr)
          addr_ctrl:
          begin
            ctrl.enable        <= wr_ctrl.enable;
            ctrl.interval_mode <= wr_ctrl.interval_mode;
          end
          addr_interval: interval_val <= pwdata;
          addr_match1:   match_val[1] <= pwdata;
          addr_match2:   match_val[2] <= pwdata;
          addr_match3:   match_val[3] <= pwdata;
          default:       ;                                // count, intr are not writable here
        endcase
      end
    end
  end

  // ------------------------------------------------------------------
  // Read mux, same cycle
  // ------------------------------------------------------------------

  always_comb
  begin
    ttc_ctrl_fld_t rd_ctrl;
    rd_ctrl               = '0;
    rd_ctrl.enable        = ctrl.enable;
    rd_ctrl.interval_mode = ctrl.interval_mode;      // restart is write only
    prdata                = '0;
    if (rd_en)
    begin
      case (paddr)
        addr_ctrl:     prdata = rd_ctrl;
        addr_interval: prdata = interval_val;
        addr_match1:   prdata = match_val[1];
        addr_match2:   prdata = match_val[2];
        addr_match3:   prdata = match_val[3];
        addr_count:    prdata = count;
        addr_intr:     prdata = {{(cnt_w-intr_w){1'b0}}, intr_reg};
        default:       prdata = {{(cnt_w-intr_w){1'b0}}, intr_en};
      endcase
    end
  end

  // Clear only ever comes from a bus read
  clr_from_read: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    clear_interrupt |-> (psel && !pwrite));

endmodule

//--- logic/ttc_counter.sv
module ttc_counter
  import ttc_cfg_pkg::*;
(
  input  logic             pclk27,
  input  logic             n_p_reset27,
  input  ttc_ctrl_t        ctrl,
  input  logic [cnt_w-1:0] interval_val,
  output logic [cnt_w-1:0] count,
  output logic             interval_evt,
  output logic             overflow_evt
);

  logic interval_hit;     // Interval mode wrap point reached
  logic overflow_hit;     // Free running wrap point reached

  assign interval_hit = ctrl.interval_mode && (count == interval_val);
  assign overflow_hit = !ctrl.interval_mode && (count == cnt_max);

  // ------------------------------------------------------------------
  // Count and wrap strobes
  // ------------------------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      count        <= '0;
      interval_evt <= 1'b0;
      overflow_evt <= 1'b0;
    end
    else
    begin
      // Strobes default low, one cycle wide
      interval_evt <= 1'b0;
      overflow_evt <= 1'b0;
      if (ctrl.enable)
      begin
        if (ctrl.restart)
        begin
          count <= '0;                        // No event on restart
        end
        else if (interval_hit)
        begin
          count        <= '0;
          interval_evt <= 1'b1;
        end
        else if (overflow_hit)
        begin
          count        <= '0;
          overflow_evt <= 1'b1;
        end
        else
        begin
          count <= count + 1'b1;
        end
      end
      // Disabled, count holds
    end
  end

  // Once inside the interval window, counting keeps it there
  interval_bound: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    (ctrl.enable && ctrl.interval_mode && (count <= interval_val))
      |=> (count <= $past(interval_val)));

endmodule

//--- logic/ttc_match.sv
module ttc_match
  import ttc_cfg_pkg::*;
(
  input  logic                        pclk27,
  input  logic                        n_p_reset27,
  input  logic                        enable,
  input  logic [cnt_w-1:0]            count,
  input  logic [n_match:1][cnt_w-1:0] match_val,
  output logic [n_match:1]            match_evt
);

  logic [n_match:1] hit;  // Combinational equality per comparator

  // ------------------------------------------------------------------
  // Comparators
  // ------------------------------------------------------------------

  always_comb
  begin
    for (int i = 1; i <= n_match; i++)
    begin
      hit[i] = enable && (count == match_val[i]);   // Only while counting
    end
  end

  // Registered strobes high the cycle after the hit
  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      match_evt <= '0;
    end
    else
    begin
      match_evt <= hit;
    end
  end

endmodule

//--- logic/ttc_interrupt_lite.sv
module ttc_interrupt_lite
  import ttc_cfg_pkg::*;
  import ttc_reg_pkg::*;
(
  input  logic              pclk27,
  input  logic              n_p_reset27,
  input  logic [intr_w-1:0] pwdata,
  input  logic              intr_en_reg_sel,
  input  logic              clear_interrupt,
  input  ttc_evt_t          evt,
  output logic              interrupt,
  output logic [intr_w-1:0] interrupt_reg_out,
  output logic [intr_w-1:0] interrupt_en_out
);

  ttc_intr_fld_t     intr_detect;        // Events in register bit order
  logic [intr_w-1:0] int_sync_reg;       // Events delayed one cycle
  logic [intr_w-1:0] int_cycle_reg;      // Rising edges one cycle wide
  logic [intr_w-1:0] interrupt_reg;
  logic [intr_w-1:0] interrupt_en_reg;
  logic              interrupt_set;      // Edge seen last cycle blocks clear

  // Map the event bus onto the register layout
  always_comb
  begin
    intr_detect          = '0;           // Bit 5 stays zero
    intr_detect.interval = evt.interval;
    intr_detect.match1   = evt.match[1];
    intr_detect.match2   = evt.match[2];
    intr_detect.match3   = evt.match[3];
    intr_detect.overflow = evt.overflow;
  end

  assign interrupt         = |interrupt_reg;
  assign interrupt_reg_out = interrupt_reg;
  assign interrupt_en_out  = interrupt_en_reg;

  // ------------------------------------------------------------------
  // Edge detect and interrupt register
  // ------------------------------------------------------------------

  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      int_sync_reg  <= '0;
      int_cycle_reg <= '0;
      interrupt_set <= 1'b0;
      interrupt_reg <= '0;
    end
    else
    begin
      int_sync_reg  <= intr_detect;
      int_cycle_reg <= intr_detect & ~int_sync_reg;    // Rising edges only
      interrupt_set <= |int_cycle_reg;
      // Edges at the clearing edge still land
      if (clear_interrupt && !interrupt_set)
        interrupt_reg <= int_cycle_reg & interrupt_en_reg;
      else
        interrupt_reg <= interrupt_reg | (int_cycle_reg & interrupt_en_reg);
    end
  end

  // Enable register with bit 5 held low
  always_ff @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
      interrupt_en_reg <= '0;
    else if (intr_en_reg_sel)
      interrupt_en_reg <= pwdata & intr_en_mask;
  end

  unused_bit_low: assert property (@(posedge pclk27) disable iff (!n_p_reset27)
    !interrupt_reg[intr_w-1]);

endmodule

//--- logic/ttc_top.sv
module ttc_top
  import ttc_cfg_pkg::*;
  import ttc_reg_pkg::*;
(
  input  logic             pclk27,
  input  logic             n_p_reset27,
  input  logic             psel,
  input  logic             pwrite,
  input  logic [2:0]       paddr,
  input  logic [cnt_w-1:0] pwdata,
  output logic [cnt_w-1:0] prdata,
  output logic             interrupt
);

  // ------------------------------------------------------------------
  // Channel nets
  // ------------------------------------------------------------------

  ttc_ctrl_t                   ctrl;
  logic [cnt_w-1:0]            interval_val;
  logic [n_match:1][cnt_w-1:0] match_val;
  logic [cnt_w-1:0]            count;
  logic                        intr_en_reg_sel;
  logic                        clear_interrupt;
  logic [intr_w-1:0]           intr_reg;     // Readback of interrupt register
  logic [intr_w-1:0]           intr_en;      // Readback of enable register
  ttc_evt_t                    evt;          // Filled by counter and match unit

  ttc_regs regs_inst (
    .pclk27          (pclk27),
    .n_p_reset27     (n_p_reset27),
    .psel            (psel),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .count           (count),
    .intr_reg        (intr_reg),
    .intr_en         (intr_en),
    .ctrl            (ctrl),
    .interval_val    (interval_val),
    .match_val       (match_val),
    .intr_en_reg_sel (intr_en_reg_sel),
    .clear_interrupt (clear_interrupt)
  );

  ttc_counter counter_inst (
    .pclk27       (pclk27),
    .n_p_reset27  (n_p_reset27),
    .ctrl         (ctrl),
    .interval_val (interval_val),
    .count        (count),
    .interval_evt (evt.interval),
    .overflow_evt (evt.overflow)
  );

  ttc_match match_inst (
    .pclk27      (pclk27),
    .n_p_reset27 (n_p_reset27),
    .enable      (ctrl.enable),
    .count       (count),
    .match_val   (match_val),
    .match_evt   (evt.match)
  );

  // Only the low bits of pwdata reach the enable register
  ttc_interrupt_lite intr_inst (
    .pclk27            (pclk27),
    .n_p_reset27       (n_p_reset27),
    .pwdata            (pwdata[intr_w-1:0]),
    .intr_en_reg_sel   (intr_en_reg_sel),
    .clear_interrupt   (clear_interrupt),
    .evt               (evt),
    .interrupt         (interrupt),
    .interrupt_reg_out (intr_reg),
    .interrupt_en_out  (intr_en)
  );

endmodule

//--- test/ttc_clkgen.sv
module ttc_clkgen #(
  parameter int period       = 20,               // Clock period in time units
  parameter int reset_cycles = 10                // Rising edges held in reset
) (
  output logic pclk27,
  output logic n_p_reset27
);

  initial
  begin
    pclk27 = 1'b0;
    forever #(period / 2) pclk27 = ~pclk27;
  end

  // Reset low from time zero, released on a rising edge
  initial
  begin
    n_p_reset27 = 1'b0;
    repeat (reset_cycles) @(posedge pclk27);
    n_p_reset27 <= 1'b1;
  end

endmodule

//--- test/ttc_checker.sv
module ttc_checker
  import ttc_cfg_pkg::*;
  import ttc_reg_pkg::*;
(
  input  logic             pclk27,
  input  logic             n_p_reset27,
  input  logic             psel,
  input  logic             pwrite,
  input  logic [2:0]       paddr,
  input  logic [cnt_w-1:0] pwdata,
  input  logic [cnt_w-1:0] prdata,
  input  logic             interrupt,
  output int               mismatches,
  output int               reads_checked,
  output int               cycles_checked,
  output int               intr_rises,         // Interrupt line went high
  output int               blocked_clears,     // Read clear held off by fresh edge
  output int               overflow_wraps      // Wraps at all ones
);

  // ------------------------------------------------------------------
  // Channel model state
  // ------------------------------------------------------------------

  logic                        m_enable, m_imode, m_restart;
  logic [cnt_w-1:0]            m_interval, m_count;
  logic [3:1][cnt_w-1:0]       m_match;
  logic                        m_int_evt, m_ovf_evt;    // Counter strobes
  logic [3:1]                  m_match_evt;             // Comparator strobes
  logic [5:0]                  m_prev;                  // Events one cycle late
  logic [5:0]                  m_edge;                  // Rising edges
  logic [5:0]                  m_intr, m_en;
  logic                        m_edge_seen;             // Any edge last cycle
  logic [5:0]                  evt_now;
  logic                        clr;
  logic                        s_wr, s_rd;              // Bus, sampled mid cycle
  logic [2:0]                  s_addr;
  logic [cnt_w-1:0]            s_wdata;
  logic [cnt_w-1:0]            exp_rd;
  logic                        prev_interrupt;

  initial
  begin
    s_wr           = 1'b0;
    s_rd           = 1'b0;
    s_addr         = '0;
    s_wdata        = '0;
    prev_interrupt = 1'b0;
  end

  // Register view of the model, unused bits zero
  function automatic logic [cnt_w-1:0] expected_read(input logic [2:0] a);
    case (a)
      addr_ctrl:     return {{(cnt_w-2){1'b0}}, m_imode, m_enable};  // restart not readable
      addr_interval: return m_interval;
      addr_match1:   return m_match[1];
      addr_match2:   return m_match[2];
      addr_match3:   return m_match[3];
      addr_count:    return m_count;
      addr_intr:     return {{(cnt_w-6){1'b0}}, m_intr};
      default:       return {{(cnt_w-6){1'b0}}, m_en};
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Compare mid cycle, where bus and outputs are settled
  // ------------------------------------------------------------------

  always @(negedge pclk27)
  begin
    s_wr    = psel && pwrite;
    s_rd    = psel && !pwrite;
    s_addr  = paddr;
    s_wdata = pwdata;
    if (n_p_reset27)
    begin
      cycles_checked++;
      if (interrupt !== (|m_intr))
      begin
        mismatches++;
        $display("MISMATCH at %0t: interrupt is %b, model expects %b (intr reg %b)",
                 $time, interrupt, |m_intr, m_intr);
      end
      if (s_rd)
      begin
        reads_checked++;
        exp_rd = expected_read(s_addr);
        if (prdata !== exp_rd)
        begin
          mismatches++;
          $display("MISMATCH at %0t: read of address %0d gives %h, model expects %h",
                   $time, s_addr, prdata, exp_rd);
        end
      end
      if (interrupt && !prev_interrupt)
        intr_rises++;
      prev_interrupt = interrupt;
    end
  end

  // ------------------------------------------------------------------
  // Advance the model on each edge, older state feeds newer
  // ------------------------------------------------------------------

  always @(posedge pclk27 or negedge n_p_reset27)
  begin
    if (!n_p_reset27)
    begin
      {m_enable, m_imode, m_restart} = '0;
      m_interval  = '0;
      m_count     = '0;
      m_match     = '0;
      {m_int_evt, m_ovf_evt} = '0;
      m_match_evt = '0;
      m_prev      = '0;
      m_edge      = '0;
      m_intr      = '0;
      m_en        = '0;
      m_edge_seen = 1'b0;
    end
    else
    begin
      // Interrupt block sees last cycle's strobes
      evt_now = {1'b0, m_ovf_evt, m_match_evt[3], m_match_evt[2], m_match_evt[1], m_int_evt};
      clr     = s_rd && (s_addr == addr_intr);
      if (clr && m_edge_seen)
        blocked_clears++;                                  // Unread interrupt kept
      if (clr && !m_edge_seen)
        m_intr = m_edge & m_en;                            // Edge at clear still lands
      else
        m_intr = m_intr | (m_edge & m_en);
      m_edge_seen = |m_edge;
      m_edge      = evt_now & ~m_prev;
      m_prev      = evt_now;
      if (s_wr && (s_addr == addr_intr_en))
        m_en = s_wdata[5:0] & 6'b01_1111;                  // Bit 5 stays zero

      // Comparators on the count before this edge
      for (int i = 1; i <= 3; i++)
        m_match_evt[i] = m_enable && (m_count == m_match[i]);

      // Counter, restart first
      m_int_evt = 1'b0;
      m_ovf_evt = 1'b0;
      if (m_enable)
      begin
        if (m_restart)
          m_count = '0;
        else if (m_imode && (m_count == m_interval))
        begin
          m_count   = '0;
          m_int_evt = 1'b1;
        end
        else if (!m_imode && (m_count == '1))
        begin
          m_count   = '0;
          m_ovf_evt = 1'b1;
          overflow_wraps++;
        end
        else
          m_count = m_count + 1'b1;
      end

      // Registers last
      m_restart = s_wr && (s_addr == addr_ctrl) && s_wdata[2];
      if (s_wr)
      begin
        case (s_addr)
          addr_ctrl:
          begin
            m_enable = s_wdata[0];
            m_imode  = s_wdata[1];
          end
          addr_interval: m_interval = s_wdata;
          addr_match1:   m_match[1] = s_wdata;
          addr_match2:   m_match[2] = s_wdata;
          addr_match3:   m_match[3] = s_wdata;
          default:       ;                                 // Read only addresses
        endcase
      end
    end
  end

endmodule

//--- test/ttc_tb.sv
module ttc_tb
  import ttc_cfg_pkg::*;
  import ttc_reg_pkg::*;
();

  localparam int clk_period   = 20;
  localparam int n_random     = 4000;                 // Random bus cycles
  localparam int n_overflow   = 65600;                // Long enough for one full wrap
  localparam int n_directed   = 60;                   // Reset, readback, closing reads
  localparam int timeout_cyc  = 10 + n_directed + n_random + n_overflow + 1000;

  logic             pclk27, n_p_reset27;
  logic             psel, pwrite;
  logic [2:0]       paddr;
  logic [cnt_w-1:0] pwdata;
  logic [cnt_w-1:0] prdata;
  logic             interrupt;
  integer           seed;
  int               mismatches, reads_checked, cycles_checked;
  int               intr_rises, blocked_clears, overflow_wraps;
  int               other_errors;

  ttc_clkgen #(.period(clk_period), .reset_cycles(10)) clkgen_inst (
    .pclk27      (pclk27),
    .n_p_reset27 (n_p_reset27)
  );

  ttc_top ttc_top_inst (
    .pclk27      (pclk27),
    .n_p_reset27 (n_p_reset27),
    .psel        (psel),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .interrupt   (interrupt)
  );

  ttc_checker checker_inst (
    .pclk27         (pclk27),
    .n_p_reset27    (n_p_reset27),
    .psel           (psel),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .interrupt      (interrupt),
    .mismatches     (mismatches),
    .reads_checked  (reads_checked),
    .cycles_checked (cycles_checked),
    .intr_rises     (intr_rises),
    .blocked_clears (blocked_clears),
    .overflow_wraps (overflow_wraps)
  );

  // ------------------------------------------------------------------
  // Bus drivers, one cycle per call
  // ------------------------------------------------------------------

  task automatic bus_cycle(input logic sel, input logic wr, input logic [2:0] a,
                           input logic [cnt_w-1:0] d);
    @(posedge pclk27);
    psel   <= sel;
    pwrite <= wr;
    paddr  <= a;
    pwdata <= d;
  endtask

  task automatic bus_write(input logic [2:0] a, input logic [cnt_w-1:0] d);
    bus_cycle(1'b1, 1'b1, a, d);
  endtask

  task automatic bus_read(input logic [2:0] a);
    bus_cycle(1'b1, 1'b0, a, '0);
  endtask

  task automatic bus_idle();
    bus_cycle(1'b0, 1'b0, '0, '0);
  endtask

  // Mix biased toward interrupt reads and small wrap and match values
  task automatic random_op();
    logic [31:0] r;
    logic [31:0] d;
    r = $random(seed);
    d = $random(seed);
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: bus_idle();
      4'd4, 4'd5, 4'd6, 4'd7: bus_read(addr_intr);
      4'd8, 4'd9:             bus_read(r[6:4]);
      4'd10, 4'd11, 4'd12:    bus_write(3'd1 + {1'b0, r[5:4]}, {12'b0, d[3:0]});
      4'd13:                  bus_write(addr_ctrl, {13'b0, d[5], d[4:3] != 2'b00,
                                                    d[2:0] != 3'b000});
      4'd14:                  bus_write(addr_intr_en, {10'b0, d[5:0]});
      default:                bus_write(r[6:4], d[cnt_w-1:0]);    // Read only too
    endcase
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  initial
  begin
    psel         = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    seed         = 32'h8cc3112b;
    other_errors = 0;
    wait (n_p_reset27 === 1'b1);

    for (int a = 0; a < 8; a++)
      bus_read(3'(a));                                  // All zero out of reset

    // Readback, bit 5 of enable masked
    bus_write(addr_interval, 16'd5);
    bus_write(addr_match1, 16'd1);
    bus_write(addr_match2, 16'd3);
    bus_write(addr_match3, 16'd4);
    bus_write(addr_intr_en, 16'h003f);
    bus_write(addr_ctrl, 16'h0003);                     // Enable, interval mode
    for (int a = 0; a < 8; a++)
      bus_read(3'(a));

    repeat (n_random) random_op();

    // Free running mode, one full wrap
    bus_write(addr_intr_en, 16'h001f);
    bus_write(addr_ctrl, 16'h0005);                     // Enable, restart
    for (int c = 0; c < n_overflow; c++)
    begin
      if (($random(seed) & 15) == 0)
        bus_read(3'(c));
      else
        bus_idle();
    end
    bus_read(addr_count);
    bus_read(addr_intr);
    bus_idle();
    bus_read(addr_intr);
    repeat (3) bus_idle();

    if (intr_rises == 0)
    begin
      other_errors++;
      $display("ERROR: the interrupt line never went high during the run");
    end
    if (blocked_clears == 0)
    begin
      other_errors++;
      $display("ERROR: no interrupt read came right after a new event edge");
    end
    if (overflow_wraps == 0)
    begin
      other_errors++;
      $display("ERROR: the counter never wrapped at all ones");
    end
    $display("Summary: %0d cycles, %0d reads checked, %0d mismatches, %0d other errors",
             cycles_checked, reads_checked, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(timeout_cyc * clk_period);
    $display("ERROR: the run did not finish within %0d cycles", timeout_cyc);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- files.f
logic/ttc_cfg_pkg.sv
logic/ttc_reg_pkg.sv
logic/ttc_regs.sv
logic/ttc_counter.sv
logic/ttc_match.sv
logic/ttc_interrupt_lite.sv
logic/ttc_top.sv
test/ttc_clkgen.sv
test/ttc_checker.sv
test/ttc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the timer channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module ttc_tb -o ttc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/ttc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0
